/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // ##########################################################################
  // sizes
  // ##########################################################################

  localparam int INST_W    = 32;
  localparam int ADDR_W    = 8;
  localparam int DATA_W    = 16;
  localparam int MEM_DEPTH = 256;
  localparam int RD_W      = 5;

  localparam int LDQ_SIZE  = 4;
  localparam int LDQ_PTR_W = 3;
  localparam int STQ_SIZE  = 4;
  // one extra bit over the index so that a full queue differs from an empty one.
  localparam int STQ_PTR_W = 3;

  // memory clearing runs over the reset cycles, a slice of words per cycle.
  localparam int CLR_CYCLES = 16;
  localparam int CLR_W      = 4;
  localparam int CLR_WORDS  = MEM_DEPTH / CLR_CYCLES;

  // ##########################################################################
  // instruction word
  // ##########################################################################

  localparam logic [1:0] CAT_LD = 2'b01;
  localparam logic [1:0] CAT_ST = 2'b10;

  // the category sits at the same place in both views.
  typedef struct packed {
    logic [1:0]                             cat;
    logic [RD_W-1:0]                        rd;
    logic [ADDR_W-1:0]                      addr;
    logic [INST_W-2-RD_W-ADDR_W-1:0]        pad;
  } lsu_ld_fmt_t;

  typedef struct packed {
    logic [1:0]                             cat;
    logic [ADDR_W-1:0]                      addr;
    logic [DATA_W-1:0]                      data;
    logic [INST_W-2-ADDR_W-DATA_W-1:0]      pad;
  } lsu_st_fmt_t;

  typedef union packed {
    lsu_ld_fmt_t ld;
    lsu_st_fmt_t st;
  } lsu_inst_u;

endpackage

`default_nettype wire

/* logic/lsu_ldq.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_ldq (
  input  logic                          i_clk,
  input  logic                          i_reset,

  input  logic                          i_disp_valid,
  input  lsu_pkg::lsu_inst_u            i_disp_inst,

  input  logic [lsu_pkg::STQ_PTR_W-1:0] i_stq_alloc_ptr,
  input  logic [lsu_pkg::STQ_PTR_W-1:0] i_stq_retire_ptr,

  input  logic                          i_ld_grant,

  output logic                          o_ldq_full,
  output logic                          o_ld_req,
  output logic [lsu_pkg::ADDR_W-1:0]    o_ld_addr,
  output logic [lsu_pkg::RD_W-1:0]      o_ld_rd
);

  logic [lsu_pkg::LDQ_PTR_W-1:0] head_ptr;
  logic [lsu_pkg::LDQ_PTR_W-1:0] tail_ptr;
  logic [lsu_pkg::LDQ_PTR_W-2:0] head_idx;
  logic [lsu_pkg::LDQ_PTR_W-2:0] tail_idx;
  logic                          ldq_empty;

  logic [lsu_pkg::RD_W-1:0]      ent_rd   [lsu_pkg::LDQ_SIZE];
  logic [lsu_pkg::ADDR_W-1:0]    ent_addr [lsu_pkg::LDQ_SIZE];
  logic [lsu_pkg::STQ_PTR_W-1:0] ent_snap [lsu_pkg::LDQ_SIZE];
  logic [lsu_pkg::LDQ_SIZE-1:0]  ent_ready;

  assign head_idx  = head_ptr[lsu_pkg::LDQ_PTR_W-2:0];
  assign tail_idx  = tail_ptr[lsu_pkg::LDQ_PTR_W-2:0];
  assign ldq_empty = (head_ptr == tail_ptr);

  assign o_ldq_full = (head_idx == tail_idx) &&
                      (head_ptr[lsu_pkg::LDQ_PTR_W-1] != tail_ptr[lsu_pkg::LDQ_PTR_W-1]);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (i_disp_valid) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (i_ld_grant) begin
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  // each load remembers how far the store queue had allocated when it arrived.
  always_ff @(posedge i_clk) begin
    if (i_disp_valid) begin
      ent_rd[tail_idx]   <= i_disp_inst.ld.rd;
      ent_addr[tail_idx] <= i_disp_inst.ld.addr;
      ent_snap[tail_idx] <= i_stq_alloc_ptr;
    end
  end

  // the retire pointer passes each snapshot exactly once, so the match is
  // kept; younger stores may retire before a stalled load gets its grant.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ent_ready <= '0;
    end else begin
      for (int i = 0; i < lsu_pkg::LDQ_SIZE; i++) begin
        if (i_disp_valid && (tail_idx == i[lsu_pkg::LDQ_PTR_W-2:0])) begin
          ent_ready[i] <= 1'b0;
        end else if (i_stq_retire_ptr == ent_snap[i]) begin
          ent_ready[i] <= 1'b1;
        end
      end
    end
  end

  assign o_ld_req  = !ldq_empty &&
                     (ent_ready[head_idx] || (i_stq_retire_ptr == ent_snap[head_idx]));
  assign o_ld_addr = ent_addr[head_idx];
  assign o_ld_rd   = ent_rd[head_idx];

  // ##########################################################################
  // checks
  // ##########################################################################

  a_no_disp_full : assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_disp_valid |-> !o_ldq_full
  ) else $error("load dispatched into a full load queue.");

  // a waiting load keeps its request until the memory stage takes it.
  a_req_hold : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_ld_req && !i_ld_grant) |=> (o_ld_req && $stable(o_ld_addr))
  ) else $error("load request dropped or changed before its grant.");

endmodule

`default_nettype wire

/* logic/lsu_stq.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_stq (
  input  logic                          i_clk,
  input  logic                          i_reset,

  input  logic                          i_disp_valid,
  input  lsu_pkg::lsu_inst_u            i_disp_inst,

  input  logic                          i_commit,
  input  logic                          i_st_grant,

  output logic                          o_stq_full,
  output logic [lsu_pkg::STQ_PTR_W-1:0] o_stq_alloc_ptr,
  output logic [lsu_pkg::STQ_PTR_W-1:0] o_stq_retire_ptr,

  output logic                          o_st_req,
  output logic [lsu_pkg::ADDR_W-1:0]    o_st_addr,
  output logic [lsu_pkg::DATA_W-1:0]    o_st_data
);

  logic [lsu_pkg::STQ_PTR_W-1:0] alloc_ptr;
  logic [lsu_pkg::STQ_PTR_W-1:0] commit_ptr;
  logic [lsu_pkg::STQ_PTR_W-1:0] retire_ptr;
  logic [lsu_pkg::STQ_PTR_W-2:0] alloc_idx;
  logic [lsu_pkg::STQ_PTR_W-2:0] retire_idx;

  logic [lsu_pkg::ADDR_W-1:0]    ent_addr [lsu_pkg::STQ_SIZE];
  logic [lsu_pkg::DATA_W-1:0]    ent_data [lsu_pkg::STQ_SIZE];

  assign alloc_idx  = alloc_ptr[lsu_pkg::STQ_PTR_W-2:0];
  assign retire_idx = retire_ptr[lsu_pkg::STQ_PTR_W-2:0];

  // a slot is free only once its store has been written, not at commit.
  assign o_stq_full = (alloc_idx == retire_idx) &&
                      (alloc_ptr[lsu_pkg::STQ_PTR_W-1] != retire_ptr[lsu_pkg::STQ_PTR_W-1]);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      alloc_ptr  <= '0;
      commit_ptr <= '0;
      retire_ptr <= '0;
    end else begin
      if (i_disp_valid) begin
        alloc_ptr <= alloc_ptr + 1'b1;
      end
      if (i_commit) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
      if (i_st_grant) begin
        retire_ptr <= retire_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_valid) begin
      ent_addr[alloc_idx] <= i_disp_inst.st.addr;
      ent_data[alloc_idx] <= i_disp_inst.st.data;
    end
  end

  assign o_stq_alloc_ptr  = alloc_ptr;
  assign o_stq_retire_ptr = retire_ptr;

  // the oldest store requests while it sits behind the commit pointer.
  assign o_st_req  = (commit_ptr != retire_ptr);
  assign o_st_addr = ent_addr[retire_idx];
  assign o_st_data = ent_data[retire_idx];

  // ##########################################################################
  // checks
  // ##########################################################################

  a_no_disp_full : assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_disp_valid |-> !o_stq_full
  ) else $error("store dispatched into a full store queue.");

  a_commit_known : assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_commit |-> (commit_ptr != alloc_ptr)
  ) else $error("commit pulse with no uncommitted store.");

endmodule

`default_nettype wire

/* logic/lsu_dmem.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_dmem (
  input  logic                       i_clk,
  input  logic                       i_reset,

  input  logic                       i_ld_req,
  input  logic [lsu_pkg::ADDR_W-1:0] i_ld_addr,
  input  logic [lsu_pkg::RD_W-1:0]   i_ld_rd,

  input  logic                       i_st_req,
  input  logic [lsu_pkg::ADDR_W-1:0] i_st_addr,
  input  logic [lsu_pkg::DATA_W-1:0] i_st_data,

  output logic                       o_ld_grant,
  output logic                       o_st_grant,

  output logic                       o_ld_done_valid,
  output logic [lsu_pkg::RD_W-1:0]   o_ld_done_rd,
  output logic [lsu_pkg::DATA_W-1:0] o_ld_done_data,

  output logic                       o_st_done_valid,
  output logic [lsu_pkg::ADDR_W-1:0] o_st_done_addr
);

  logic [lsu_pkg::DATA_W-1:0] mem [lsu_pkg::MEM_DEPTH];
  logic [lsu_pkg::CLR_W-1:0]  clr_cnt;

  // the single port serves stores first and a load simply waits a cycle.
  assign o_st_grant = i_st_req;
  assign o_ld_grant = i_ld_req && !i_st_req;

  // steps through the word slices while reset is held and rests at zero after.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      clr_cnt <= clr_cnt + 1'b1;
    end else begin
      clr_cnt <= '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int w = 0; w < lsu_pkg::CLR_WORDS; w++) begin
        mem[clr_cnt * lsu_pkg::CLR_WORDS + w] <= '0;
      end
    end else if (o_st_grant) begin
      mem[i_st_addr] <= i_st_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ld_grant) begin
      o_ld_done_rd   <= i_ld_rd;
      o_ld_done_data <= mem[i_ld_addr];
    end
    if (o_st_grant) begin
      o_st_done_addr <= i_st_addr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ld_done_valid <= 1'b0;
      o_st_done_valid <= 1'b0;
    end else begin
      o_ld_done_valid <= o_ld_grant;
      o_st_done_valid <= o_st_grant;
    end
  end

  // a load held back by a store must still be asking for the same word next cycle.
  a_ld_held : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (i_ld_req && i_st_req) |=> (i_ld_req && $stable(i_ld_addr))
  ) else $error("load request dropped or changed while a store held it back.");

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
  input  logic                       i_clk,
  input  logic                       i_reset,

  input  logic                       i_disp_valid,
  input  lsu_pkg::lsu_inst_u         i_disp_inst,
  input  logic                       i_commit,

  output logic                       o_ldq_full,
  output logic                       o_stq_full,

  output logic                       o_ld_done_valid,
  output logic [lsu_pkg::RD_W-1:0]   o_ld_done_rd,
  output logic [lsu_pkg::DATA_W-1:0] o_ld_done_data,

  output logic                       o_st_done_valid,
  output logic [lsu_pkg::ADDR_W-1:0] o_st_done_addr
);

  logic                          w_ldq_disp_valid;
  logic                          w_stq_disp_valid;

  logic [lsu_pkg::STQ_PTR_W-1:0] w_stq_alloc_ptr;
  logic [lsu_pkg::STQ_PTR_W-1:0] w_stq_retire_ptr;

  logic                          w_ld_req;
  logic [lsu_pkg::ADDR_W-1:0]    w_ld_addr;
  logic [lsu_pkg::RD_W-1:0]      w_ld_rd;
  logic                          w_ld_grant;

  logic                          w_st_req;
  logic [lsu_pkg::ADDR_W-1:0]    w_st_addr;
  logic [lsu_pkg::DATA_W-1:0]    w_st_data;
  logic                          w_st_grant;

  // anything that is neither a load nor a store falls through here.
  assign w_ldq_disp_valid = i_disp_valid && (i_disp_inst.ld.cat == lsu_pkg::CAT_LD);
  assign w_stq_disp_valid = i_disp_valid && (i_disp_inst.ld.cat == lsu_pkg::CAT_ST);

  // ##########################################################################
  // load queue
  // ##########################################################################

  lsu_ldq u_ldq (
    .i_clk            (i_clk           ),
    .i_reset          (i_reset         ),
    .i_disp_valid     (w_ldq_disp_valid),
    .i_disp_inst      (i_disp_inst     ),
    .i_stq_alloc_ptr  (w_stq_alloc_ptr ),
    .i_stq_retire_ptr (w_stq_retire_ptr),
    .i_ld_grant       (w_ld_grant      ),
    .o_ldq_full       (o_ldq_full      ),
    .o_ld_req         (w_ld_req        ),
    .o_ld_addr        (w_ld_addr       ),
    .o_ld_rd          (w_ld_rd         )
  );

  // ##########################################################################
  // store queue
  // ##########################################################################

  lsu_stq u_stq (
    .i_clk            (i_clk           ),
    .i_reset          (i_reset         ),
    .i_disp_valid     (w_stq_disp_valid),
    .i_disp_inst      (i_disp_inst     ),
    .i_commit         (i_commit        ),
    .i_st_grant       (w_st_grant      ),
    .o_stq_full       (o_stq_full      ),
    .o_stq_alloc_ptr  (w_stq_alloc_ptr ),
    .o_stq_retire_ptr (w_stq_retire_ptr),
    .o_st_req         (w_st_req        ),
    .o_st_addr        (w_st_addr       ),
    .o_st_data        (w_st_data       )
  );

  // ##########################################################################
  // data memory
  // ##########################################################################

  lsu_dmem u_dmem (
    .i_clk            (i_clk          ),
    .i_reset          (i_reset        ),
    .i_ld_req         (w_ld_req       ),
    .i_ld_addr        (w_ld_addr      ),
    .i_ld_rd          (w_ld_rd        ),
    .i_st_req         (w_st_req       ),
    .i_st_addr        (w_st_addr      ),
    .i_st_data        (w_st_data      ),
    .o_ld_grant       (w_ld_grant     ),
    .o_st_grant       (w_st_grant     ),
    .o_ld_done_valid  (o_ld_done_valid),
    .o_ld_done_rd     (o_ld_done_rd   ),
    .o_ld_done_data   (o_ld_done_data ),
    .o_st_done_valid  (o_st_done_valid),
    .o_st_done_addr   (o_st_done_addr )
  );

endmodule

`default_nettype wire

/* dv/lsu_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_clock (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // reset spans 16 rising edges, one per memory slice being cleared.
  initial begin
    o_reset = 1'b1;
    repeat (16) @(posedge o_clk);
    #1 o_reset = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

  logic                       clk;
  logic                       reset;
  logic                       disp_valid;
  lsu_pkg::lsu_inst_u         disp_inst;
  logic                       commit;
  logic                       ldq_full;
  logic                       stq_full;
  logic                       ld_done_valid;
  logic [lsu_pkg::RD_W-1:0]   ld_done_rd;
  logic [lsu_pkg::DATA_W-1:0] ld_done_data;
  logic                       st_done_valid;
  logic [lsu_pkg::ADDR_W-1:0] st_done_addr;

  // one entry per test line with its operands already decoded.
  byte unsigned cmd_q [$];
  int           arg_a_q [$];
  int           arg_b_q [$];
  int           cycle_limit = 0;
  int           cycles = 0;

  logic [lsu_pkg::DATA_W-1:0] ref_mem [lsu_pkg::MEM_DEPTH];
  logic [lsu_pkg::RD_W-1:0]   exp_rd_q [$];
  logic [lsu_pkg::DATA_W-1:0] exp_data_q [$];
  int                         exp_older_q [$];
  logic [lsu_pkg::ADDR_W-1:0] exp_st_addr_q [$];
  int                         stores_sent = 0;
  int                         commits_sent = 0;
  int                         stores_done = 0;
  logic                       ldq_full_seen = 1'b0;
  logic                       stq_full_seen = 1'b0;

  lsu_clock u_clock (.o_clk(clk), .o_reset(reset));

  lsu_top uut (
    .i_clk           (clk          ),
    .i_reset         (reset        ),
    .i_disp_valid    (disp_valid   ),
    .i_disp_inst     (disp_inst    ),
    .i_commit        (commit       ),
    .o_ldq_full      (ldq_full     ),
    .o_stq_full      (stq_full     ),
    .o_ld_done_valid (ld_done_valid),
    .o_ld_done_rd    (ld_done_rd   ),
    .o_ld_done_data  (ld_done_data ),
    .o_st_done_valid (st_done_valid),
    .o_st_done_addr  (st_done_addr )
  );

  task automatic end_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped.");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      end_with_failure("value mismatch.");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic read_tests();
    int    fd;
    int    a;
    int    b;
    logic  ok;
    string line;
    string rest;
    fd = $fopen("dv/lsu_tests.txt", "r");
    if (fd == 0) begin
      end_with_failure("cannot open dv/lsu_tests.txt.");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 1 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      a = 0;
      b = 0;
      rest = line.substr(1, line.len() - 1);
      case (line.getc(0))
        "L", "S": ok = ($sscanf(rest, "%h %h", a, b) == 2);
        "W":      ok = ($sscanf(rest, "%d", a) == 1);
        "C":      ok = 1'b1;
        default:  ok = 1'b0;
      endcase
      if (!ok) begin
        end_with_failure({"unreadable test line: ", line});
      end
      cmd_q.push_back(line.getc(0));
      arg_a_q.push_back(a);
      arg_b_q.push_back(b);
    end
    $fclose(fd);
    cycle_limit = 20 * cmd_q.size() + 100;
  endtask

  // ##########################################################################
  // stimulus
  // ##########################################################################

  task automatic dispatch_load(input int rd, input int addr);
    while (ldq_full) begin
      next_cycle();
    end
    disp_inst         = '0;
    disp_inst.ld.cat  = lsu_pkg::CAT_LD;
    disp_inst.ld.rd   = rd[lsu_pkg::RD_W-1:0];
    disp_inst.ld.addr = addr[lsu_pkg::ADDR_W-1:0];
    disp_valid        = 1'b1;
    // every older store is already in the reference, so this is the value seen.
    exp_rd_q.push_back(rd[lsu_pkg::RD_W-1:0]);
    exp_data_q.push_back(ref_mem[addr[lsu_pkg::ADDR_W-1:0]]);
    exp_older_q.push_back(stores_sent);
    next_cycle();
    disp_valid = 1'b0;
  endtask

  task automatic dispatch_store(input int addr, input int data);
    while (stq_full) begin
      next_cycle();
    end
    disp_inst         = '0;
    disp_inst.st.cat  = lsu_pkg::CAT_ST;
    disp_inst.st.addr = addr[lsu_pkg::ADDR_W-1:0];
    disp_inst.st.data = data[lsu_pkg::DATA_W-1:0];
    disp_valid        = 1'b1;
    ref_mem[addr[lsu_pkg::ADDR_W-1:0]] = data[lsu_pkg::DATA_W-1:0];
    exp_st_addr_q.push_back(addr[lsu_pkg::ADDR_W-1:0]);
    stores_sent = stores_sent + 1;
    next_cycle();
    disp_valid = 1'b0;
  endtask

  task automatic send_commit();
    commit       = 1'b1;
    commits_sent = commits_sent + 1;
    next_cycle();
    commit = 1'b0;
  endtask

  initial begin
    disp_valid = 1'b0;
    disp_inst  = '0;
    commit     = 1'b0;
    foreach (ref_mem[i]) begin
      ref_mem[i] = '0;
    end
    read_tests();
    @(negedge reset);
    foreach (cmd_q[i]) begin
      case (cmd_q[i])
        "L":     dispatch_load(arg_a_q[i], arg_b_q[i]);
        "S":     dispatch_store(arg_a_q[i], arg_b_q[i]);
        "C":     send_commit();
        default: repeat (arg_a_q[i]) next_cycle();
      endcase
    end
    while (exp_rd_q.size() != 0 || exp_st_addr_q.size() != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    if (ldq_full_seen && stq_full_seen && stores_done == stores_sent) begin
      $display("TEST PASS");
      $finish;
    end else begin
      end_with_failure("a queue never filled or a store was never written.");
    end
  end

  // ##########################################################################
  // response checking on the falling clock edge
  // ##########################################################################

  always @(negedge clk) begin
    if (!reset) begin
      if (ldq_full) begin
        ldq_full_seen = 1'b1;
      end
      if (stq_full) begin
        stq_full_seen = 1'b1;
      end
      if (st_done_valid) begin
        if (exp_st_addr_q.size() == 0) begin
          end_with_failure("store report with no store outstanding.");
        end
        if (stores_done >= commits_sent) begin
          end_with_failure("store written before it was committed.");
        end
        check("o_st_done_addr", exp_st_addr_q.pop_front(), st_done_addr);
        stores_done = stores_done + 1;
      end
      if (ld_done_valid) begin
        if (exp_rd_q.size() == 0) begin
          end_with_failure("load report with no load outstanding.");
        end
        if (stores_done < exp_older_q.pop_front()) begin
          end_with_failure("load reported before an older store was written.");
        end
        check("o_ld_done_rd", exp_rd_q.pop_front(), ld_done_rd);
        check("o_ld_done_data", exp_data_q.pop_front(), ld_done_data);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      end_with_failure($sformatf("timeout after %0d cycles.", cycles));
    end
  end

endmodule

`default_nettype wire

/* dv/lsu_tests.txt */
# L rd addr and S addr data take hex operands, C sends one commit, W n idles n cycles.
# lines starting with # are skipped.
L 01 10
S 20 beef
L 02 20
W 5
C
L 03 20
W 4
# four loads wait behind an uncommitted store, the fifth stalls on a full queue
S 30 1234
L 04 30
L 05 31
L 06 30
L 07 10
C
L 08 30
W 6
# four stores fill the store queue, the fifth stalls until one is written
S 40 0001
S 41 0002
S 42 0003
S 40 0004
C
S 43 0005
C
C
W 2
C
C
L 09 40
L 0a 41
L 0b 42
L 0c 43
L 0d 20
L 0e 30

/* lsu_top.f */
logic/lsu_pkg.sv
logic/lsu_ldq.sv
logic/lsu_stq.sv
logic/lsu_dmem.sv
logic/lsu_top.sv
dv/lsu_clock.sv
dv/lsu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := lsu_tb
FILELIST  := lsu_top.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)
